// ==== vlog.f ====
+incdir+.
rom_seq_pkg.sv
rom_seq_decode.sv
rom_seq_execute.sv
rom_seq_result.sv
rom_seq_top.sv
tb_rom_seq.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module tb_rom_seq \
    --Mdir obj_dir \
    -o tb_rom_seq_sim \
    -f vlog.f

# Exit status of the simulation is the test result
./obj_dir/tb_rom_seq_sim

// ==== tb_rom_seq.sv ====
// Testbench for the program sequencer
// Clock and reset, LCG program and ack-delay generator, host driver,
// reference model of the address registers, trace checks and timeout

`default_nettype none

`include "rom_seq_params.svh"

module tb_rom_seq;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR  = 400;
    localparam int MAX_CYCLES = NUM_INSTR * 20 + 200;

    logic                clk;
    logic                rst;
    logic                ins_req;
    rom_seq_pkg::instr_u ins_word;
    logic                ins_ack;
    logic                trc_req;
    logic                trc_ack;
    rom_seq_pkg::trace_t trc;

    // Pre-drawn stimulus
    logic [`RS_INSTR_W-1:0] prog [NUM_INSTR];
    logic [2:0]             ack_dly [NUM_INSTR];

    // Reference model state
    logic [`RS_ADDR_W-1:0] m_pc;
    logic [`RS_ADDR_W-1:0] m_pr;
    logic [`RS_ADDR_W-1:0] m_pt;
    logic [`RS_IDX_W-1:0]  m_i;
    logic [7:0]            m_seq;
    rom_seq_pkg::trace_t   exp_q[$];

    // Monitor state
    logic                ins_req_q;
    logic                ins_ack_q;
    logic                trc_req_q;
    rom_seq_pkg::trace_t trc_q;
    int                  n_traces;
    int                  cyc;

    rom_seq_top dut (
        .clk      (clk),
        .rst      (rst),
        .ins_req  (ins_req),
        .ins_word (ins_word),
        .ins_ack  (ins_ack),
        .trc_req  (trc_req),
        .trc_ack  (trc_ack),
        .trc      (trc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("ERR %s got %h expected %h", name, got, want);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Apply one instruction to the model and queue the trace it should produce
    task automatic model_step(input logic [`RS_INSTR_W-1:0] w);
        logic [3:0]            code;
        logic [1:0]            r;
        logic [`RS_IDX_W-1:0]  ja;
        logic [`RS_ADDR_W-1:0] imm;
        logic [`RS_ADDR_W-1:0] nxt;
        logic [`RS_ADDR_W-1:0] dat;
        rom_seq_pkg::trace_t   t;
        code = w[21:18];
        r    = w[17:16];
        imm  = w[15:0];
        ja   = w[11:0];
        if (code > 4'd9)
            code = 4'd0;    // Undefined codes advance
        nxt = m_pc + 16'd1;
        dat = '0;
        case (code)
            rom_seq_pkg::OP_GOTO_JA, rom_seq_pkg::OP_CALL_JA:
                nxt = {m_pc[15:12], ja};
            rom_seq_pkg::OP_RET:
                nxt = m_pr;
            rom_seq_pkg::OP_GOTO_PT, rom_seq_pkg::OP_CALL_PT:
                nxt = m_pt;
            rom_seq_pkg::OP_READ_PT, rom_seq_pkg::OP_READ_PT_I:
                dat = m_pt;
            rom_seq_pkg::OP_STORE: begin
                if (r == 2'd0)
                    dat = m_pt;
                else if (r == 2'd1)
                    dat = m_pr;
                else if (r == 2'd2)
                    dat = {{4{m_i[11]}}, m_i};   // Sign-extended increment
            end
            default: ;
        endcase
        if (code == 4'd2 || code == 4'd5)
            m_pr = m_pc + 16'd1;
        if (code == 4'd6) begin
            if (r == 2'd0)
                m_pt = imm;
            else if (r == 2'd1)
                m_pr = imm;
            else if (r == 2'd2)
                m_i = imm[11:0];
        end
        if (code == 4'd7)
            m_pt = {m_pt[15:12], m_pt[11:0] + 12'd1};
        if (code == 4'd8)
            m_pt = {m_pt[15:12], m_pt[11:0] + m_i};   // Wraps inside the page
        t.op       = rom_seq_pkg::op_e'(code);
        t.seq      = m_seq;
        t.pc       = m_pc;
        t.rom_addr = nxt;
        t.data     = dat;
        exp_q.push_back(t);
        m_pc  = nxt;
        m_seq = m_seq + 8'd1;
    endtask

    // Four-phase host side, entered on a rising edge
    task automatic send_instr(input logic [`RS_INSTR_W-1:0] w);
        ins_req  <= 1'b1;
        ins_word <= rom_seq_pkg::instr_u'(w);
        do @(posedge clk); while (!ins_ack);
        ins_req <= 1'b0;
        do @(posedge clk); while (ins_ack);
    endtask

    task automatic check_trace;
        rom_seq_pkg::trace_t e;
        if (exp_q.size() == 0) begin
            $display("A trace record arrived with no instruction outstanding");
            $display("*** TEST FAILED ***");
            $fatal(1, "unexpected trace record");
        end
        e = exp_q.pop_front();
        check_field("trc.op", 32'(trc.op), 32'(e.op));
        check_field("trc.seq", 32'(trc.seq), 32'(e.seq));
        check_field("trc.pc", 32'(trc.pc), 32'(e.pc));
        check_field("trc.rom_addr", 32'(trc.rom_addr), 32'(e.rom_addr));
        check_field("trc.data", 32'(trc.data), 32'(e.data));
        n_traces++;
    endtask

    // Handshake monitor and trace checks
    always @(posedge clk) begin
        if (rst) begin
            ins_req_q <= 1'b0;
            ins_ack_q <= 1'b0;
            trc_req_q <= 1'b0;
        end else begin
            ins_req_q <= ins_req;   // Request seen at the capture edge
            ins_ack_q <= ins_ack;
            trc_req_q <= trc_req;
            trc_q     <= trc;
            if (ins_ack && !ins_ack_q) begin
                assert (ins_req_q) else begin
                    $display("ins_ack rose while ins_req was low");
                    $display("*** TEST FAILED ***");
                    $fatal(1, "instruction handshake violated");
                end
            end
            if (trc_req && trc_req_q) begin
                assert (trc == trc_q) else begin
                    $display("ERR trc changed under trc_req: %h was %h", trc, trc_q);
                    $display("*** TEST FAILED ***");
                    $fatal(1, "trace not steady");
                end
            end
            if (trc_req && !trc_req_q)
                check_trace();
        end
    end

    // Host side of the trace link with random back-pressure
    initial begin
        trc_ack = 1'b0;
        for (int k = 0; k < NUM_INSTR; k++) begin
            do @(posedge clk); while (!trc_req);
            repeat (ack_dly[k]) @(posedge clk);
            trc_ack <= 1'b1;
            do @(posedge clk); while (trc_req);
            trc_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] rng;
        logic [3:0]  code;
        rst      = 1'b1;
        ins_req  = 1'b0;
        ins_word = '0;
        cyc      = 0;
        n_traces = 0;
        m_pc     = '0;
        m_pr     = '0;
        m_pt     = '0;
        m_i      = '0;
        m_seq    = '0;

        // Draw the program and ack delays up front
        rng = 32'h36c1_0401;
        for (int k = 0; k < NUM_INSTR; k++) begin
            rng = lcg_next(rng);
            if (rng[31:29] == 3'd0)
                code = 4'd10 + 4'(rng[28:24] % 5'd6);   // Some undefined codes
            else
                code = 4'(rng[28:20] % 9'd10);
            rng     = lcg_next(rng);
            prog[k] = {code, rng[31:14]};
            rng        = lcg_next(rng);
            ack_dly[k] = 3'(rng[31:16] % 16'd6);
        end

        // Directed opening with a pt++ page wrap and a jump in a nonzero page
        prog[0] = {rom_seq_pkg::OP_LOAD, 2'd0, 16'h5fff};
        prog[1] = {rom_seq_pkg::OP_READ_PT, 18'h0};        // pt low bits wrap to 000
        prog[2] = {rom_seq_pkg::OP_STORE, 2'd0, 16'h0};
        prog[3] = {rom_seq_pkg::OP_GOTO_PT, 18'h0};
        prog[4] = {rom_seq_pkg::OP_GOTO_JA, 6'h0, 12'h123};
        prog[5] = {rom_seq_pkg::OP_LOAD, 2'd2, 16'ha801};  // Negative increment
        prog[6] = {rom_seq_pkg::OP_STORE, 2'd2, 16'h0};
        prog[7] = {rom_seq_pkg::OP_STORE, 2'd3, 16'h0};

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_field("ins_ack", 32'(ins_ack), 32'h0);
        check_field("trc_req", 32'(trc_req), 32'h0);

        for (int k = 0; k < NUM_INSTR; k++) begin
            model_step(prog[k]);
            send_instr(prog[k]);
        end

        while (n_traces < NUM_INSTR) @(posedge clk);
        repeat (20) @(posedge clk);    // Catch any stray record

        if (n_traces == NUM_INSTR && exp_q.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("Got %0d traces for %0d instructions", n_traces, NUM_INSTR);
            $display("*** TEST FAILED ***");
            $fatal(1, "trace count mismatch");
        end
    end

endmodule

`default_nettype wire

// ==== rom_seq_top.sv ====
// Program sequencer top level
// Decode, execute and result stages between the
// instruction link and the trace link

`default_nettype none

module rom_seq_top (
    input  logic                clk,
    input  logic                rst,
    // Instruction link
    input  logic                ins_req,
    input  rom_seq_pkg::instr_u ins_word,
    output logic                ins_ack,
    // Trace link
    output logic                trc_req,
    input  logic                trc_ack,
    output rom_seq_pkg::trace_t trc
);

    rom_seq_pkg::dec_op_t op;
    logic                 op_valid;
    logic                 op_take;
    rom_seq_pkg::trace_t  trc_in;
    logic                 trc_valid;
    logic                 slot_free;

    rom_seq_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .ins_req  (ins_req),
        .ins_word (ins_word),
        .ins_ack  (ins_ack),
        .op       (op),
        .op_valid (op_valid),
        .op_take  (op_take)
    );

    rom_seq_execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .op_take   (op_take),
        .slot_free (slot_free),
        .trc_in    (trc_in),
        .trc_valid (trc_valid)
    );

    rom_seq_result u_result (
        .clk       (clk),
        .rst       (rst),
        .trc_in    (trc_in),
        .trc_valid (trc_valid),
        .slot_free (slot_free),
        .trc_req   (trc_req),
        .trc       (trc),
        .trc_ack   (trc_ack)
    );

endmodule

`default_nettype wire

// ==== rom_seq_result.sv ====
// Trace output stage
// Holding slot with retire counter stamp and
// the four-phase req/ack handshake back to the host

`default_nettype none

`include "rom_seq_params.svh"

module rom_seq_result (
    input  logic                clk,
    input  logic                rst,
    input  rom_seq_pkg::trace_t trc_in,
    input  logic                trc_valid,
    output logic                slot_free,
    output logic                trc_req,
    output rom_seq_pkg::trace_t trc,
    input  logic                trc_ack
);

    typedef enum logic [1:0] {
        TR_IDLE,    // Slot empty
        TR_REQ,     // Record offered
        TR_DONE     // Waiting for ack to drop
    } tr_state_e;

    tr_state_e            state;
    logic [`RS_SEQ_W-1:0] seq_cnt;

    assign slot_free = (state == TR_IDLE);
    assign trc_req   = (state == TR_REQ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= TR_IDLE;
            seq_cnt <= '0;
        end else begin
            case (state)
                TR_IDLE: begin
                    if (trc_valid) begin
                        state   <= TR_REQ;
                        seq_cnt <= seq_cnt + `RS_SEQ_W'(1);  // Wraps
                    end
                end
                TR_REQ:  if (trc_ack) state <= TR_DONE;
                TR_DONE: if (!trc_ack) state <= TR_IDLE;
                default: state <= TR_IDLE;
            endcase
        end
    end

    // Slot contents, steady while trc_req is high
    always_ff @(posedge clk) begin
        if (trc_valid && state == TR_IDLE) begin
            trc     <= trc_in;
            trc.seq <= seq_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== rom_seq_execute.sv ====
// ROM address arithmetic unit
// Program counter, return register, table pointer and increment register,
// next-address selection and trace record generation

`default_nettype none

`include "rom_seq_params.svh"

module rom_seq_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  rom_seq_pkg::dec_op_t op,
    input  logic                 op_valid,
    output logic                 op_take,
    input  logic                 slot_free,
    output rom_seq_pkg::trace_t  trc_in,
    output logic                 trc_valid
);

    logic [`RS_ADDR_W-1:0] pc;     // Program counter
    logic [`RS_ADDR_W-1:0] pr;     // Return register
    logic [`RS_ADDR_W-1:0] pt;     // Table pointer
    logic [`RS_IDX_W-1:0]  i;      // Increment register

    logic [`RS_ADDR_W-1:0] seq_pc;
    logic [`RS_ADDR_W-1:0] next_pc;
    logic [`RS_ADDR_W-1:0] next_pt;
    logic [`RS_IDX_W-1:0]  pt_step;
    logic [`RS_ADDR_W-1:0] i_sext;
    logic [`RS_ADDR_W-1:0] reg_dout;
    logic [`RS_ADDR_W-1:0] rep_data;
    rom_seq_pkg::trace_t   rec;

    // Result slot must be free before an op retires
    assign op_take = op_valid && slot_free;

    assign seq_pc  = pc + `RS_ADDR_W'(1);
    assign pt_step = op.istep ? i : `RS_IDX_W'(1);
    // Post-increment stays inside the 4K page
    assign next_pt = {pt[`RS_ADDR_W-1:`RS_IDX_W], pt[`RS_IDX_W-1:0] + pt_step};
    assign i_sext  = {{(`RS_ADDR_W-`RS_IDX_W){i[`RS_IDX_W-1]}}, i};

    always_comb begin
        if (op.jump_ja)
            next_pc = {pc[`RS_ADDR_W-1:`RS_IDX_W], op.ja};  // Page bits kept
        else if (op.via_pt)
            next_pc = pt;
        else if (op.ret)
            next_pc = pr;
        else
            next_pc = seq_pc;
    end

    // Register read-back
    always_comb begin
        case (op.reg_sel)
            2'd0:    reg_dout = pt;
            2'd1:    reg_dout = pr;
            2'd2:    reg_dout = i_sext;
            default: reg_dout = '0;
        endcase
    end

    always_comb begin
        if (op.pt_read)
            rep_data = pt;            // Pre-increment table address
        else if (op.store)
            rep_data = reg_dout;
        else
            rep_data = '0;
    end

    always_comb begin
        rec          = '0;
        rec.op       = op.op;
        rec.pc       = pc;
        rec.rom_addr = next_pc;
        rec.data     = rep_data;
        // seq is stamped by the result stage
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= '0;
            pr        <= '0;
            pt        <= '0;
            i         <= '0;
            trc_valid <= 1'b0;
        end else begin
            trc_valid <= op_take;
            if (op_take) begin
                pc <= next_pc;
                if (op.call) pr <= seq_pc;

                if (op.load) begin
                    case (op.reg_sel)
                        2'd0:    pt <= op.imm;
                        2'd1:    pr <= op.imm;
                        2'd2:    i  <= op.imm[`RS_IDX_W-1:0];
                        default: ;    // No target
                    endcase
                end

                if (op.pt_read) pt <= next_pt;
            end
        end
    end

    // Trace payload
    always_ff @(posedge clk) begin
        if (op_take) trc_in <= rec;
    end

endmodule

`default_nettype wire

// ==== rom_seq_decode.sv ====
// Instruction intake and decoding
// Four-phase req/ack intake FSM, one-word holding slot
// and the opcode decoder driving the execute stage

`default_nettype none

module rom_seq_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                ins_req,
    input  rom_seq_pkg::instr_u ins_word,
    output logic                ins_ack,
    output rom_seq_pkg::dec_op_t op,
    output logic                op_valid,
    input  logic                op_take
);

    typedef enum logic {
        IN_IDLE,
        IN_ACK     // Word captured, waiting for req to drop
    } in_state_e;

    in_state_e           state;
    rom_seq_pkg::instr_u word_q;
    logic                capture;

    // Only take a word when the slot is empty and the last ack is gone
    assign capture = (state == IN_IDLE) && ins_req && !op_valid;
    assign ins_ack = (state == IN_ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IN_IDLE;
            op_valid <= 1'b0;
        end else begin
            case (state)
                IN_IDLE: if (capture) state <= IN_ACK;
                IN_ACK:  if (!ins_req) state <= IN_IDLE;
                default: state <= IN_IDLE;
            endcase

            if (op_take)
                op_valid <= 1'b0;   // Execute has it
            else if (capture)
                op_valid <= 1'b1;
        end
    end

    // Holding slot
    always_ff @(posedge clk) begin
        if (capture) word_q <= ins_word;
    end

    always_comb begin
        op         = '0;
        op.op      = word_q.jmp.op;
        op.ja      = word_q.jmp.ja;     // Jump view
        op.reg_sel = word_q.ld.r;       // Load view
        op.imm     = word_q.ld.imm;

        case (word_q.jmp.op)
            rom_seq_pkg::OP_NOP: ;
            rom_seq_pkg::OP_GOTO_JA: op.jump_ja = 1'b1;
            rom_seq_pkg::OP_CALL_JA: begin
                op.jump_ja = 1'b1;
                op.call    = 1'b1;
            end
            rom_seq_pkg::OP_RET:     op.ret = 1'b1;
            rom_seq_pkg::OP_GOTO_PT: op.via_pt = 1'b1;
            rom_seq_pkg::OP_CALL_PT: begin
                op.via_pt = 1'b1;
                op.call   = 1'b1;
            end
            rom_seq_pkg::OP_LOAD:    op.load = 1'b1;
            rom_seq_pkg::OP_READ_PT: op.pt_read = 1'b1;
            rom_seq_pkg::OP_READ_PT_I: begin
                op.pt_read = 1'b1;
                op.istep   = 1'b1;
            end
            rom_seq_pkg::OP_STORE:   op.store = 1'b1;
            default:                 op.op = rom_seq_pkg::OP_NOP;  // Plain advance
        endcase
    end

endmodule

`default_nettype wire

// ==== rom_seq_pkg.sv ====
// Shared types for the program sequencer
// Opcode enum, the two instruction views and their union,
// decoded control flags and the trace record

`default_nettype none

package rom_seq_pkg;

`include "rom_seq_params.svh"

    typedef enum logic [`RS_OP_W-1:0] {
        OP_NOP       = 4'd0,
        OP_GOTO_JA   = 4'd1,
        OP_CALL_JA   = 4'd2,
        OP_RET       = 4'd3,
        OP_GOTO_PT   = 4'd4,
        OP_CALL_PT   = 4'd5,
        OP_LOAD      = 4'd6,
        OP_READ_PT   = 4'd7,   // *pt++
        OP_READ_PT_I = 4'd8,   // *pt++i
        OP_STORE     = 4'd9
    } op_e;

    // Jump words carry an in-page target
    typedef struct packed {
        op_e                 op;
        logic [5:0]          spare;
        logic [`RS_IDX_W-1:0] ja;
    } jump_view_t;

    // Load and store words carry a register select and an immediate
    typedef struct packed {
        op_e                  op;
        logic [1:0]           r;    // 0 pt, 1 pr, 2 i, 3 none
        logic [`RS_ADDR_W-1:0] imm;
    } load_view_t;

    typedef union packed {
        jump_view_t jmp;
        load_view_t ld;
    } instr_u;

    typedef struct packed {
        logic                  jump_ja;  // goto or call to ja
        logic                  call;     // Save return address
        logic                  ret;
        logic                  via_pt;   // Jump target is pt
        logic                  load;
        logic                  store;
        logic                  pt_read;
        logic                  istep;    // Post-increment pt by i
        logic [1:0]            reg_sel;
        logic [`RS_IDX_W-1:0]  ja;
        logic [`RS_ADDR_W-1:0] imm;
        op_e                   op;
    } dec_op_t;

    typedef struct packed {
        op_e                   op;
        logic [`RS_SEQ_W-1:0]  seq;
        logic [`RS_ADDR_W-1:0] pc;
        logic [`RS_ADDR_W-1:0] rom_addr;  // Next program address
        logic [`RS_ADDR_W-1:0] data;
    } trace_t;

endpackage

`default_nettype wire

// ==== rom_seq_params.svh ====
// Width macros for the program sequencer
// Address, page offset, opcode, instruction and retire counter widths

`ifndef ROM_SEQ_PARAMS_SVH
`define ROM_SEQ_PARAMS_SVH

// Program address and address register width
`define RS_ADDR_W  16

// In-page offset and increment register width
`define RS_IDX_W   12

`define RS_OP_W    4
`define RS_INSTR_W 22  // Opcode plus 18 payload bits

`define RS_SEQ_W   8   // Retire counter

`endif
